// File: hw/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data and byte address width
`define MIPS_XLEN 32

// register file address width, 32 entries
`define MIPS_REG_AW 5

// instruction memory word address width
`define MIPS_IMEM_AW 8

`endif

// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

`default_nettype wire

// File: hw/mips_pipe_pkg.sv
`include "mips_defines.svh"

`default_nettype none

package mips_pipe_pkg;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  alu_src;
        logic                  branch;
        logic                  halt;
        mips_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
        logic [`MIPS_REG_AW-1:0] rs_addr;
        logic [`MIPS_REG_AW-1:0] rt_addr;
        logic [`MIPS_REG_AW-1:0] dst_addr;
        logic [`MIPS_XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`MIPS_XLEN-1:0]   alu_res;
        logic [`MIPS_XLEN-1:0]   store_data;
        logic [`MIPS_REG_AW-1:0] dst_addr;
    } ex_mem_t;

    typedef struct packed {
        logic                    valid;
        logic                    reg_write;
        logic                    halt;
        logic [`MIPS_XLEN-1:0]   data;
        logic [`MIPS_REG_AW-1:0] dst_addr;
    } mem_wb_t;

    // register write port, also the late forwarding source
    typedef struct packed {
        logic                    en;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                    en;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   value;
    } fwd_t;

    typedef struct packed {
        logic                  taken;
        logic [`MIPS_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                     valid;
        logic [`MIPS_IMEM_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]    data;
    } imem_wr_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: hw/mips_fetch.sv
`include "mips_defines.svh"

`default_nettype none

module mips_fetch (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  mips_pipe_pkg::imem_wr_t    i_imem_wr,
    input  wire                        i_stall,
    input  mips_pipe_pkg::redirect_t   i_redirect,
    input  wire                        i_halt_seen,
    output mips_pipe_pkg::if_id_t      o_if_id
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [`MIPS_XLEN-1:0] imem [0:(1 << `MIPS_IMEM_AW)-1];
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] fetch_word;
    logic                  fetch_halt;
    logic                  frozen;
    if_id_t                if_id_q;

    // loaded from outside, normally while reset is held
    always_ff @(posedge i_clk) begin
        if (i_imem_wr.valid) begin
            imem[i_imem_wr.addr] <= i_imem_wr.data;
        end
    end

    assign fetch_word = imem[pc[`MIPS_IMEM_AW+1:2]];
    assign fetch_halt = (opcode_e'(fetch_word[31:26]) == OP_HALT);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc            <= '0;
            frozen        <= 1'b0;
            if_id_q.valid <= 1'b0;
        end else if (i_redirect.taken && !i_halt_seen) begin
            // taken branch overrides a halt freeze
            pc            <= i_redirect.target;
            frozen        <= 1'b0;
            if_id_q.valid <= 1'b0;
        end else if (i_stall) begin
            pc <= pc;
        end else if (frozen || i_halt_seen) begin
            if_id_q.valid <= 1'b0;
        end else begin
            // halt word enters IF/ID once, then pc stays put
            pc            <= fetch_halt ? pc : pc + `MIPS_XLEN'd4;
            frozen        <= fetch_halt;
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc;
            if_id_q.instr <= fetch_word;
        end
    end

    assign o_if_id = if_id_q;

endmodule

`default_nettype wire

// File: hw/mips_decode.sv
`include "mips_defines.svh"

`default_nettype none

module mips_decode (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  mips_pipe_pkg::if_id_t      i_if_id,
    input  mips_pipe_pkg::wb_t         i_wb,
    input  mips_pipe_pkg::redirect_t   i_redirect,
    output mips_pipe_pkg::id_ex_t      o_id_ex,
    output logic                       o_stall
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [`MIPS_XLEN-1:0]   regs [0:(1 << `MIPS_REG_AW)-1];
    logic [5:0]              op;
    logic [5:0]              funct;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [`MIPS_REG_AW-1:0] dst_addr;
    logic [`MIPS_XLEN-1:0]   rs_val;
    logic [`MIPS_XLEN-1:0]   rt_val;
    logic [`MIPS_XLEN-1:0]   imm;
    logic                    uses_rs;
    logic                    uses_rt;
    logic                    load_pending;
    logic                    stall;
    ctrl_t                   ctrl;
    id_ex_t                  id_ex_q;

    assign op    = i_if_id.instr[31:26];
    assign rs    = i_if_id.instr[25:21];
    assign rt    = i_if_id.instr[20:16];
    assign rd    = i_if_id.instr[15:11];
    assign funct = i_if_id.instr[5:0];
    assign imm   = {{(`MIPS_XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    always_comb begin
        ctrl     = '0;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        dst_addr = rt;
        case (opcode_e'(op))
            OP_RTYPE: begin
                dst_addr       = rd;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct_e'(funct))
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // unknown function runs as a nop
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                uses_rs        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                uses_rs         = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_wb.en && (i_wb.addr != '0)) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // r0 is hardwired, write-back in the same cycle passes straight through
    assign rs_val = (rs == '0) ? '0 :
                    (i_wb.en && (i_wb.addr == rs)) ? i_wb.data : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (i_wb.en && (i_wb.addr == rt)) ? i_wb.data : regs[rt];

    // load in ID/EX whose result is needed right away
    assign load_pending = id_ex_q.valid && id_ex_q.ctrl.mem_read &&
                          (id_ex_q.dst_addr != '0);
    assign stall = i_if_id.valid && load_pending &&
                   ((uses_rs && (rs == id_ex_q.dst_addr)) ||
                    (uses_rt && (rt == id_ex_q.dst_addr)));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            id_ex_q.valid <= 1'b0;
        end else if (stall || i_redirect.taken) begin
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q.valid    <= i_if_id.valid;
            id_ex_q.ctrl     <= ctrl;
            id_ex_q.pc       <= i_if_id.pc;
            id_ex_q.rs_val   <= rs_val;
            id_ex_q.rt_val   <= rt_val;
            id_ex_q.rs_addr  <= rs;
            id_ex_q.rt_addr  <= rt;
            id_ex_q.dst_addr <= dst_addr;
            id_ex_q.imm      <= imm;
        end
    end

    assign o_id_ex = id_ex_q;
    assign o_stall = stall;

endmodule

`default_nettype wire

// File: hw/mips_execute.sv
`include "mips_defines.svh"

`default_nettype none

module mips_execute (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  mips_pipe_pkg::id_ex_t      i_id_ex,
    input  mips_pipe_pkg::wb_t         i_wb,
    output mips_pipe_pkg::ex_mem_t     o_ex_mem,
    output mips_pipe_pkg::fwd_t        o_fwd,
    output mips_pipe_pkg::redirect_t   o_redirect
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] rt_fwd;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_res;
    fwd_t                  fwd;
    ex_mem_t               ex_mem_q;

    // newest value wins, EX/MEM before write-back
    function automatic logic [`MIPS_XLEN-1:0] pick_operand(
        input logic [`MIPS_REG_AW-1:0] addr,
        input logic [`MIPS_XLEN-1:0]   reg_val,
        input fwd_t                    ex_src,
        input wb_t                     wb_src
    );
        if (ex_src.en && (ex_src.addr == addr)) begin
            return ex_src.value;
        end else if (wb_src.en && (wb_src.addr == addr)) begin
            return wb_src.data;
        end
        return reg_val;
    endfunction

    assign fwd.en    = ex_mem_q.valid && ex_mem_q.ctrl.reg_write && (ex_mem_q.dst_addr != '0);
    assign fwd.addr  = ex_mem_q.dst_addr;
    assign fwd.value = ex_mem_q.alu_res;

    assign op_a   = pick_operand(i_id_ex.rs_addr, i_id_ex.rs_val, fwd, i_wb);
    assign rt_fwd = pick_operand(i_id_ex.rt_addr, i_id_ex.rt_val, fwd, i_wb);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_fwd;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {{(`MIPS_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_res = '0;
        endcase
    end

    // beq resolves here, no delay slot
    assign o_redirect.taken  = i_id_ex.valid && i_id_ex.ctrl.branch && (op_a == rt_fwd);
    assign o_redirect.target = i_id_ex.pc + `MIPS_XLEN'd4 +
                               {i_id_ex.imm[`MIPS_XLEN-3:0], 2'b00};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ex_mem_q.valid <= 1'b0;
        end else begin
            ex_mem_q.valid      <= i_id_ex.valid;
            ex_mem_q.ctrl       <= i_id_ex.ctrl;
            ex_mem_q.alu_res    <= alu_res;
            ex_mem_q.store_data <= rt_fwd;
            ex_mem_q.dst_addr   <= i_id_ex.dst_addr;
        end
    end

    assign o_ex_mem = ex_mem_q;
    assign o_fwd    = fwd;

endmodule

`default_nettype wire

// File: hw/mips_mem_wb.sv
`include "mips_defines.svh"

`default_nettype none

module mips_mem_wb (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  mips_pipe_pkg::ex_mem_t     i_ex_mem,
    input  wire [`MIPS_XLEN-1:0]       i_dmem_rdata,
    output mips_pipe_pkg::dmem_req_t   o_dmem_req,
    output mips_pipe_pkg::wb_t         o_wb,
    output logic                       o_halt_seen,
    output logic                       o_halted
);
    import mips_pipe_pkg::*;

    mem_wb_t mem_wb_q;
    logic    halt_in_wb;
    logic    halted;

    assign o_dmem_req.valid = i_ex_mem.valid &&
                              (i_ex_mem.ctrl.mem_read || i_ex_mem.ctrl.mem_write);
    assign o_dmem_req.write = i_ex_mem.ctrl.mem_write;
    assign o_dmem_req.addr  = i_ex_mem.alu_res;
    assign o_dmem_req.wdata = i_ex_mem.store_data;

    // load data arrives in the same cycle as the request
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            mem_wb_q.valid <= 1'b0;
        end else begin
            mem_wb_q.valid     <= i_ex_mem.valid;
            mem_wb_q.reg_write <= i_ex_mem.ctrl.reg_write;
            mem_wb_q.halt      <= i_ex_mem.ctrl.halt;
            mem_wb_q.data      <= i_ex_mem.ctrl.mem_to_reg ? i_dmem_rdata : i_ex_mem.alu_res;
            mem_wb_q.dst_addr  <= i_ex_mem.dst_addr;
        end
    end

    assign o_wb.en   = mem_wb_q.valid && mem_wb_q.reg_write && (mem_wb_q.dst_addr != '0);
    assign o_wb.addr = mem_wb_q.dst_addr;
    assign o_wb.data = mem_wb_q.data;

    assign halt_in_wb = mem_wb_q.valid && mem_wb_q.halt;

    // sticky until reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            halted <= 1'b0;
        end else if (halt_in_wb) begin
            halted <= 1'b1;
        end
    end

    assign o_halt_seen = halt_in_wb || halted;
    assign o_halted    = halted;

endmodule

`default_nettype wire

// File: hw/mips_core.sv
`include "mips_defines.svh"

`default_nettype none

module mips_core (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  mips_pipe_pkg::imem_wr_t    i_imem_wr,
    output mips_pipe_pkg::dmem_req_t   o_dmem_req,
    input  wire [`MIPS_XLEN-1:0]       i_dmem_rdata,
    output logic                       o_halted
);
    import mips_pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    wb_t       wb;
    logic      stall;
    logic      halt_seen;

    mips_fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_imem_wr   (i_imem_wr),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .i_halt_seen (halt_seen),
        .o_if_id     (if_id)
    );

    mips_decode u_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_if_id    (if_id),
        .i_wb       (wb),
        .i_redirect (redirect),
        .o_id_ex    (id_ex),
        .o_stall    (stall)
    );

    // EX/MEM forwarding is consumed inside execute
    mips_execute u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_id_ex    (id_ex),
        .i_wb       (wb),
        .o_ex_mem   (ex_mem),
        .o_fwd      (),
        .o_redirect (redirect)
    );

    mips_mem_wb u_mem_wb (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ex_mem     (ex_mem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_req   (o_dmem_req),
        .o_wb         (wb),
        .o_halt_seen  (halt_seen),
        .o_halted     (o_halted)
    );

endmodule

`default_nettype wire

// File: tests/mips_tb_programs.svh
`ifndef MIPS_TB_PROGRAMS_SVH
`define MIPS_TB_PROGRAMS_SVH

// standard mips encodings for the supported subset
localparam logic [5:0]  OPC_RTYPE   = 6'h00;
localparam logic [5:0]  OPC_BEQ     = 6'h04;
localparam logic [5:0]  OPC_ADDIU   = 6'h09;
localparam logic [5:0]  OPC_LW      = 6'h23;
localparam logic [5:0]  OPC_SW      = 6'h2b;
localparam logic [5:0]  FUNCT_ADDU  = 6'h21;
localparam logic [5:0]  FUNCT_SUBU  = 6'h23;
localparam logic [5:0]  FUNCT_AND   = 6'h24;
localparam logic [5:0]  FUNCT_OR    = 6'h25;
localparam logic [5:0]  FUNCT_SLT   = 6'h2a;
localparam logic [31:0] HALT_WORD   = 32'hffff_ffff;

function automatic logic [31:0] encode_rtype(input logic [5:0] funct, input int rd,
                                             input int rs, input int rt);
    return {OPC_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
endfunction

// field order as encoded: rs, then rt, then the 16-bit immediate
function automatic logic [31:0] encode_itype(input logic [5:0] opcode, input int rs,
                                             input int rt, input int imm);
    return {opcode, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic logic [31:0] sign_extend16(input logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

task automatic clear_program();
    prog_words.delete();
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// every alu op feeds the next, then each result is stored
task automatic build_arith_program();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    logic [31:0] v5;
    logic [31:0] v6;
    logic [31:0] v7;
    int          r;
    clear_program();
    v1 = sign_extend16(16'h1234);
    v2 = sign_extend16(16'hfffb);
    v3 = v1 + v2;
    v4 = v3 - v1;
    v5 = v4 & v3;
    v6 = v5 | v2;
    v7 = ($signed(v6) < $signed(v5)) ? 32'd1 : 32'd0;
    prog_words.push_back(encode_itype(OPC_ADDIU, 0, 1, 'h1234));
    prog_words.push_back(encode_itype(OPC_ADDIU, 0, 2, 'hfffb));
    prog_words.push_back(encode_rtype(FUNCT_ADDU, 3, 1, 2));
    prog_words.push_back(encode_rtype(FUNCT_SUBU, 4, 3, 1));
    prog_words.push_back(encode_rtype(FUNCT_AND, 5, 4, 3));
    prog_words.push_back(encode_rtype(FUNCT_OR, 6, 5, 2));
    prog_words.push_back(encode_rtype(FUNCT_SLT, 7, 6, 5));
    for (r = 3; r <= 7; r++) begin
        prog_words.push_back(encode_itype(OPC_SW, 0, r, (r - 3) * 4));
    end
    // a write to r0 must be lost
    prog_words.push_back(encode_itype(OPC_ADDIU, 0, 0, 77));
    prog_words.push_back(encode_itype(OPC_SW, 0, 0, 20));
    prog_words.push_back(HALT_WORD);
    prog_words.push_back(encode_itype(OPC_SW, 0, 1, 24));
    expect_store(32'd0, v3);
    expect_store(32'd4, v4);
    expect_store(32'd8, v5);
    expect_store(32'd12, v6);
    expect_store(32'd16, v7);
    expect_store(32'd20, 32'd0);
endtask

task automatic build_load_use_program();
    clear_program();
    prog_words.push_back(encode_itype(OPC_LW, 0, 1, 8));
    prog_words.push_back(encode_itype(OPC_ADDIU, 1, 2, -128));
    prog_words.push_back(encode_itype(OPC_SW, 0, 2, 12));
    // second load feeds the store data operand
    prog_words.push_back(encode_itype(OPC_LW, 0, 3, 16));
    prog_words.push_back(encode_itype(OPC_SW, 0, 3, 20));
    prog_words.push_back(HALT_WORD);
    expect_store(32'd12, dmem[2] + sign_extend16(16'hff80));
    expect_store(32'd20, dmem[4]);
endtask

task automatic build_branch_program();
    clear_program();
    prog_words.push_back(encode_itype(OPC_ADDIU, 0, 1, 7));
    prog_words.push_back(encode_itype(OPC_ADDIU, 0, 2, 7));
    // word 2, taken to word 5
    prog_words.push_back(encode_itype(OPC_BEQ, 1, 2, 2));
    prog_words.push_back(encode_itype(OPC_SW, 0, 1, 0));
    prog_words.push_back(encode_itype(OPC_SW, 0, 2, 4));
    prog_words.push_back(encode_itype(OPC_SW, 0, 1, 8));
    // not taken, r1 holds 7
    prog_words.push_back(encode_itype(OPC_BEQ, 1, 0, 2));
    prog_words.push_back(encode_itype(OPC_SW, 0, 2, 12));
    prog_words.push_back(HALT_WORD);
    prog_words.push_back(encode_itype(OPC_SW, 0, 1, 16));
    expect_store(32'd8, 32'd7);
    expect_store(32'd12, 32'd7);
endtask

`endif

// File: tests/mips_core_tb.sv
`include "mips_defines.svh"

`default_nettype none

module mips_core_tb;
    import mips_pipe_pkg::*;

    localparam int HALT_TIMEOUT = 300;
    localparam int HALT_HOLD    = 20;
    localparam int DMEM_WORDS   = 64;

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic                  rst_n_q = 1'b1;
    imem_wr_t              imem_wr = '0;
    dmem_req_t             dmem_req;
    logic [`MIPS_XLEN-1:0] dmem_rdata;
    logic                  halted;

    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] lfsr = 32'h3bb5;
    logic [31:0] prog_words [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          timeouts = 0;

    `include "mips_tb_programs.svh"

    mips_core mips_core_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_imem_wr    (imem_wr),
        .o_dmem_req   (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_halted     (halted)
    );

    always #5 clk = ~clk;

    // reset level the core took at the last rising edge
    always @(posedge clk) begin
        rst_n_q <= rst_n;
    end

    // data memory answers in the same cycle
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    task automatic value_mismatch(input string name, input logic [31:0] want,
                                  input logic [31:0] got);
        value_errors++;
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_dmem();
        logic [31:0] w;
        int          a;
        int          b;
        w = '0;
        for (a = 0; a < DMEM_WORDS; a++) begin
            for (b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);
                w    = {w[30:0], lfsr[0]};
            end
            dmem[a] = w;
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] want_addr;
        logic [31:0] want_data;
        assert (exp_addr.size() != 0) else begin
            other_errors++;
            $display("%0t: store of %h to %h when no store was expected", $time, data, addr);
        end
        if (exp_addr.size() != 0) begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            assert (addr == want_addr) else value_mismatch("dmem_req.addr", want_addr, addr);
            assert (data == want_data) else value_mismatch("dmem_req.wdata", want_data, data);
        end
        dmem[addr[7:2]] = data;
    endtask

    always @(negedge clk) begin
        if (rst_n && dmem_req.valid && dmem_req.write) begin
            check_store(dmem_req.addr, dmem_req.wdata);
        end
    end

    // quiet outputs while reset is held
    assert property (@(negedge clk) rst_n || rst_n_q || !dmem_req.valid)
        else value_mismatch("dmem_req.valid", 32'd0, {31'd0, dmem_req.valid});
    assert property (@(negedge clk) rst_n || rst_n_q || !halted)
        else value_mismatch("o_halted", 32'd0, {31'd0, halted});
    assert property (@(negedge clk) !(halted && dmem_req.valid && dmem_req.write))
        else begin
            other_errors++;
            $display("%0t: store issued after the core halted", $time);
        end

    task automatic run_program(input string name);
        int i;
        int cycles;
        @(posedge clk);
        rst_n <= 1'b0;
        // program goes in while reset is held
        for (i = 0; i < prog_words.size(); i++) begin
            imem_wr.valid <= 1'b1;
            imem_wr.addr  <= i[`MIPS_IMEM_AW-1:0];
            imem_wr.data  <= prog_words[i];
            @(posedge clk);
        end
        imem_wr.valid <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!dmem_req.valid) else value_mismatch("dmem_req.valid", 32'd0, 32'd1);
        assert (!halted) else value_mismatch("o_halted", 32'd0, 32'd1);
        cycles = 0;
        while (!halted && (cycles < HALT_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timeouts++;
            $display("%s: timed out after %0d cycles waiting for halt", name, cycles);
        end else begin
            for (i = 0; i < HALT_HOLD; i++) begin
                @(negedge clk);
                assert (halted) else value_mismatch("o_halted", 32'd1, 32'd0);
            end
            assert (exp_addr.size() == 0) else begin
                other_errors++;
                $display("%s: %0d expected stores never appeared", name, exp_addr.size());
            end
        end
        @(posedge clk);
        rst_n <= 1'b0;
    endtask

    initial begin
        fill_dmem();
        build_arith_program();
        run_program("arith");
        fill_dmem();
        build_load_use_program();
        run_program("load-use");
        fill_dmem();
        build_branch_program();
        run_program("branch");
        $display("value errors %0d, other errors %0d, timeouts %0d",
                 value_errors, other_errors, timeouts);
        if ((value_errors + other_errors + timeouts) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+tests
hw/mips_isa_pkg.sv
hw/mips_pipe_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_mem_wb.sv
hw/mips_core.sv
tests/mips_core_tb.sv

// File: Makefile
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= mips_core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh tests/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
